// ==== acf_accumulator.sv ====
// ------------------------------------------------------------
// per-block lag sums over the sample stream
// snapshot pulses two cycles after the last sample of a block
// ------------------------------------------------------------
`include "acf_cfg.svh"

module acf_accumulator (
    input  logic                iClock,
    input  logic                rst_n,
    input  logic                sample_valid,
    input  acf_pkg::sample_t    sample,
    output logic                snapshot_valid,
    output acf_pkg::acf_block_t snapshot
);
    localparam int CNT_W  = $clog2(`ACF_BLOCK_SIZE);
    localparam int PROD_W = 2 * `ACF_SAMPLE_W;
    localparam logic [CNT_W-1:0] LAST_IDX = CNT_W'(`ACF_BLOCK_SIZE - 1);

    acf_pkg::sample_t         hist [0:`ACF_LAGS];
    logic signed [PROD_W-1:0] prod [0:`ACF_LAGS];
    acf_pkg::acf_sum_t        sums [0:`ACF_LAGS];
    logic [CNT_W-1:0]         count;
    logic                     hist_new;
    logic                     hist_last;
    logic                     prod_new;
    logic                     prod_last;

    // ------------------------------------------------------------
    // stage 1 holds a delay line of the newest samples
    // ------------------------------------------------------------
    always_ff @(posedge iClock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i <= `ACF_LAGS; i++) begin
                hist[i] <= '0;
            end
            count     <= '0;
            hist_new  <= 1'b0;
            hist_last <= 1'b0;
        end else begin
            hist_new  <= sample_valid;
            hist_last <= sample_valid && (count == LAST_IDX);
            if (sample_valid) begin
                count <= (count == LAST_IDX) ? '0 : count + 1'b1;
            end
            if (hist_last) begin
                // the finished block leaves the line and a new first sample starts clean
                for (int i = 1; i <= `ACF_LAGS; i++) begin
                    hist[i] <= '0;
                end
                hist[0] <= sample_valid ? sample : '0;
            end else if (sample_valid) begin
                hist[0] <= sample;
                for (int i = 1; i <= `ACF_LAGS; i++) begin
                    hist[i] <= hist[i-1];
                end
            end
        end
    end

    // stage 2 forms one product per lag against the newest sample
    always_ff @(posedge iClock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i <= `ACF_LAGS; i++) begin
                prod[i] <= '0;
            end
            prod_new  <= 1'b0;
            prod_last <= 1'b0;
        end else begin
            prod_new  <= hist_new;
            prod_last <= hist_last;
            if (hist_new) begin
                for (int i = 0; i <= `ACF_LAGS; i++) begin
                    prod[i] <= hist[0] * hist[i];
                end
            end
        end
    end

    // ------------------------------------------------------------
    // stage 3 keeps the working sums and clears them at hand-off
    // ------------------------------------------------------------
    always_ff @(posedge iClock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i <= `ACF_LAGS; i++) begin
                sums[i] <= '0;
            end
            snapshot_valid <= 1'b0;
        end else begin
            snapshot_valid <= prod_new && prod_last;
            if (prod_new) begin
                for (int i = 0; i <= `ACF_LAGS; i++) begin
                    if (prod_last) begin
                        sums[i] <= '0;
                    end else begin
                        sums[i] <= sums[i] + prod[i];
                    end
                end
            end
        end
    end

    always_ff @(posedge iClock) begin
        if (prod_new && prod_last) begin
            for (int i = 0; i <= `ACF_LAGS; i++) begin
                snapshot.sums[i] <= sums[i] + prod[i];
            end
        end
    end

endmodule

// ==== acf_cfg.svh ====
// ------------------------------------------------------------
// build constants for the block autocorrelation design
// include wherever lag count, block size or widths are needed
// ------------------------------------------------------------
`ifndef ACF_CFG_SVH
`define ACF_CFG_SVH

// highest lag computed
// lag 0 is the block energy and serves as the normalizer
`define ACF_LAGS       4

// samples per block, products never cross a block edge
`define ACF_BLOCK_SIZE 64

`define ACF_SAMPLE_W   16
`define ACF_SUM_W      43
`define ACF_LAG_IDX_W  4

`endif

// ==== acf_normalizer.sv ====
// ------------------------------------------------------------
// sequences conversion and division of one block into records
// blocks arriving while busy are dropped and flagged
// ------------------------------------------------------------
`include "acf_cfg.svh"

module acf_normalizer (
    input  logic                iClock,
    input  logic                rst_n,
    input  logic                snapshot_valid,
    input  acf_pkg::acf_block_t snapshot,
    output logic                conv_valid,
    output acf_pkg::acf_sum_t   conv_value,
    input  logic                conv_done,
    input  acf_pkg::fp32_t      conv_result,
    output logic                div_start,
    output acf_pkg::fp32_t      div_num,
    output acf_pkg::fp32_t      div_den,
    input  logic                div_done,
    input  acf_pkg::fp32_t      div_quotient,
    output logic                coef_valid,
    output acf_pkg::acf_coef_t  coef,
    output logic                block_done,
    output logic                overrun
);
    localparam int LAG_W = `ACF_LAG_IDX_W;
    localparam logic [LAG_W-1:0] LAST_LAG = LAG_W'(`ACF_LAGS);

    acf_pkg::norm_state_e state;
    acf_pkg::acf_block_t  blk;
    logic [LAG_W-1:0]     lag;
    logic                 last_lag;

    assign last_lag = (lag == LAST_LAG);
    // the converter always works on the current lag of the private copy
    assign conv_value = blk.sums[lag];

    // ------------------------------------------------------------
    // control
    // ------------------------------------------------------------
    always_ff @(posedge iClock or negedge rst_n) begin
        if (!rst_n) begin
            state      <= acf_pkg::NORM_IDLE;
            lag        <= '0;
            conv_valid <= 1'b0;
            div_start  <= 1'b0;
            coef_valid <= 1'b0;
            block_done <= 1'b0;
            overrun    <= 1'b0;
        end else begin
            conv_valid <= 1'b0;
            div_start  <= 1'b0;
            coef_valid <= 1'b0;
            block_done <= 1'b0;
            overrun    <= snapshot_valid && (state != acf_pkg::NORM_IDLE);
            case (state)
                acf_pkg::NORM_IDLE: begin
                    if (snapshot_valid) begin
                        lag        <= '0;
                        conv_valid <= 1'b1;
                        state      <= acf_pkg::NORM_CONV_DEN;
                    end
                end
                acf_pkg::NORM_CONV_DEN: begin
                    // lag 0 goes through once more as its own numerator
                    if (conv_done) begin
                        conv_valid <= 1'b1;
                        state      <= acf_pkg::NORM_CONV_NUM;
                    end
                end
                acf_pkg::NORM_CONV_NUM: begin
                    if (conv_done) begin
                        div_start <= 1'b1;
                        state     <= acf_pkg::NORM_DIVIDE;
                    end
                end
                acf_pkg::NORM_DIVIDE: begin
                    if (div_done) begin
                        coef_valid <= 1'b1;
                        block_done <= last_lag;
                        state      <= acf_pkg::NORM_EMIT;
                    end
                end
                acf_pkg::NORM_EMIT: begin
                    if (last_lag) begin
                        state <= acf_pkg::NORM_IDLE;
                    end else begin
                        lag        <= lag + 1'b1;
                        conv_valid <= 1'b1;
                        state      <= acf_pkg::NORM_CONV_NUM;
                    end
                end
                default: state <= acf_pkg::NORM_IDLE;
            endcase
        end
    end

    // ------------------------------------------------------------
    // block copy, operands and output record
    // ------------------------------------------------------------
    always_ff @(posedge iClock) begin
        if (state == acf_pkg::NORM_IDLE && snapshot_valid) begin
            blk <= snapshot;
        end
        if (state == acf_pkg::NORM_CONV_DEN && conv_done) begin
            div_den <= conv_result;
        end
        if (state == acf_pkg::NORM_CONV_NUM && conv_done) begin
            div_num <= conv_result;
        end
        if (state == acf_pkg::NORM_DIVIDE && div_done) begin
            coef.lag     <= lag;
            coef.raw_sum <= blk.sums[lag];
            coef.norm    <= div_quotient;
        end
    end

endmodule

// ==== acf_pkg.sv ====
// ------------------------------------------------------------
// shared types for the autocorrelation datapath and its records
// ------------------------------------------------------------
`include "acf_cfg.svh"

package acf_pkg;

    typedef logic signed [`ACF_SAMPLE_W-1:0] sample_t;
    typedef logic signed [`ACF_SUM_W-1:0]    acf_sum_t;

    // single precision layout, no special values are produced
    typedef struct packed {
        logic        sign;
        logic [7:0]  exponent;
        logic [22:0] fraction;
    } fp32_t;

    // all lag sums of one block, index 0 holds lag 0
    typedef struct packed {
        acf_sum_t [`ACF_LAGS:0] sums;
    } acf_block_t;

    typedef struct packed {
        logic [`ACF_LAG_IDX_W-1:0] lag;
        acf_sum_t                  raw_sum;
        fp32_t                     norm;
    } acf_coef_t;

    typedef enum logic [2:0] {
        NORM_IDLE,
        NORM_CONV_DEN,
        NORM_CONV_NUM,
        NORM_DIVIDE,
        NORM_EMIT
    } norm_state_e;

endpackage

// ==== autocorrelation_top.sv ====
// ------------------------------------------------------------
// block autocorrelation with normalized float coefficients
// ------------------------------------------------------------
module autocorrelation_top (
    input  logic               iClock,
    input  logic               rst_n,
    input  logic               sample_valid,
    input  acf_pkg::sample_t   sample,
    output logic               coef_valid,
    output acf_pkg::acf_coef_t coef,
    output logic               block_done,
    output logic               overrun
);
    logic                snapshot_valid;
    acf_pkg::acf_block_t snapshot;
    logic                conv_valid;
    acf_pkg::acf_sum_t   conv_value;
    logic                conv_done;
    acf_pkg::fp32_t      conv_result;
    logic                div_start;
    acf_pkg::fp32_t      div_num;
    acf_pkg::fp32_t      div_den;
    logic                div_done;
    acf_pkg::fp32_t      div_quotient;

    acf_accumulator acc0 (
        .iClock         (iClock),
        .rst_n          (rst_n),
        .sample_valid   (sample_valid),
        .sample         (sample),
        .snapshot_valid (snapshot_valid),
        .snapshot       (snapshot)
    );

    acf_normalizer norm0 (
        .iClock         (iClock),
        .rst_n          (rst_n),
        .snapshot_valid (snapshot_valid),
        .snapshot       (snapshot),
        .conv_valid     (conv_valid),
        .conv_value     (conv_value),
        .conv_done      (conv_done),
        .conv_result    (conv_result),
        .div_start      (div_start),
        .div_num        (div_num),
        .div_den        (div_den),
        .div_done       (div_done),
        .div_quotient   (div_quotient),
        .coef_valid     (coef_valid),
        .coef           (coef),
        .block_done     (block_done),
        .overrun        (overrun)
    );

    int_to_float conv0 (
        .iClock    (iClock),
        .rst_n     (rst_n),
        .in_valid  (conv_valid),
        .value     (conv_value),
        .out_valid (conv_done),
        .result    (conv_result)
    );

    fp_divider div0 (
        .iClock      (iClock),
        .rst_n       (rst_n),
        .div_start   (div_start),
        .numerator   (div_num),
        .denominator (div_den),
        .div_done    (div_done),
        .quotient    (div_quotient)
    );

endmodule

// ==== fp_divider.sv ====
// ------------------------------------------------------------
// iterative single precision divider with truncation
// 26 cycles from start to done, one cycle for a zero operand
// ------------------------------------------------------------
module fp_divider (
    input  logic           iClock,
    input  logic           rst_n,
    input  logic           div_start,
    input  acf_pkg::fp32_t numerator,
    input  acf_pkg::fp32_t denominator,
    output logic           div_done,
    output acf_pkg::fp32_t quotient
);
    localparam int SIG_W = 24;
    localparam int Q_W   = SIG_W + 1;

    logic              busy;
    logic [4:0]        step;
    logic [Q_W-1:0]    rem;
    logic [SIG_W-1:0]  divisor;
    logic [Q_W-1:0]    q_bits;
    logic signed [9:0] exp_base;
    logic              q_sign;
    logic              operand_zero;
    logic              rem_ge;
    logic [Q_W-1:0]    rem_sub;
    logic [Q_W-1:0]    q_next;

    // a zero exponent only ever comes from an all-zero operand here
    assign operand_zero = (numerator.exponent == 8'd0) || (denominator.exponent == 8'd0);

    // one restoring step per cycle
    assign rem_ge  = rem >= {1'b0, divisor};
    assign rem_sub = rem_ge ? rem - {1'b0, divisor} : rem;
    assign q_next  = {q_bits[Q_W-2:0], rem_ge};

    always_ff @(posedge iClock or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            step     <= '0;
            div_done <= 1'b0;
        end else begin
            div_done <= 1'b0;
            if (div_start) begin
                busy     <= !operand_zero;
                step     <= '0;
                div_done <= operand_zero;
            end else if (busy) begin
                step <= step + 1'b1;
                if (step == 5'(Q_W - 1)) begin
                    busy     <= 1'b0;
                    div_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge iClock) begin
        if (div_start) begin
            rem      <= {2'b01, numerator.fraction};
            divisor  <= {1'b1, denominator.fraction};
            q_bits   <= '0;
            exp_base <= $signed({2'b00, numerator.exponent})
                        - $signed({2'b00, denominator.exponent}) + 10'sd126;
            q_sign   <= numerator.sign ^ denominator.sign;
            if (operand_zero) begin
                quotient <= '0;
            end
        end else if (busy) begin
            q_bits <= q_next;
            rem    <= {rem_sub[Q_W-2:0], 1'b0};
            if (step == 5'(Q_W - 1)) begin
                quotient.sign <= q_sign;
                // the significand ratio lies in (0.5, 2), so at most one bit of shift
                if (q_next[Q_W-1]) begin
                    quotient.exponent <= 8'(exp_base + 10'sd1);
                    quotient.fraction <= q_next[Q_W-2:1];
                end else begin
                    quotient.exponent <= 8'(exp_base);
                    quotient.fraction <= q_next[Q_W-3:0];
                end
            end
        end
    end

endmodule

// ==== int_to_float.sv ====
// ------------------------------------------------------------
// signed sum to single precision, truncating, two cycle latency
// ------------------------------------------------------------
`include "acf_cfg.svh"

module int_to_float (
    input  logic              iClock,
    input  logic              rst_n,
    input  logic              in_valid,
    input  acf_pkg::acf_sum_t value,
    output logic              out_valid,
    output acf_pkg::fp32_t    result
);
    localparam int SUM_W = `ACF_SUM_W;
    localparam int POS_W = $clog2(SUM_W);

    logic [SUM_W-1:0] mag_in;
    logic             stage1_valid;
    logic             stage1_sign;
    logic [SUM_W-1:0] stage1_mag;
    logic [POS_W-1:0] stage1_pos;
    logic [SUM_W-1:0] norm_mag;

    // position of the highest set bit, zero for a zero input
    function automatic logic [POS_W-1:0] lead_one(input logic [SUM_W-1:0] v);
        logic [POS_W-1:0] p;
        p = '0;
        for (int i = 0; i < SUM_W; i++) begin
            if (v[i]) begin
                p = POS_W'(i);
            end
        end
        return p;
    endfunction

    assign mag_in   = value[SUM_W-1] ? ~value + 1'b1 : value;
    // leading one moves to the top bit, the bits below the fraction fall off
    assign norm_mag = stage1_mag << (POS_W'(SUM_W - 1) - stage1_pos);

    always_ff @(posedge iClock or negedge rst_n) begin
        if (!rst_n) begin
            stage1_valid <= 1'b0;
            out_valid    <= 1'b0;
        end else begin
            stage1_valid <= in_valid;
            out_valid    <= stage1_valid;
        end
    end

    always_ff @(posedge iClock) begin
        stage1_sign <= value[SUM_W-1];
        stage1_mag  <= mag_in;
        stage1_pos  <= lead_one(mag_in);
        if (stage1_mag == '0) begin
            result <= '0;
        end else begin
            result.sign     <= stage1_sign;
            result.exponent <= 8'd127 + 8'(stage1_pos);
            result.fraction <= norm_mag[SUM_W-2 -: 23];
        end
    end

endmodule

// ==== tb_autocorrelation.sv ====
// ------------------------------------------------------------
// self-checking testbench for the block autocorrelation top level
// runs a table of sample blocks and compares every record to a model
// ------------------------------------------------------------
`include "acf_cfg.svh"

module tb_autocorrelation;

    localparam int NUM_ROWS = 8;
    localparam int BLOCK    = `ACF_BLOCK_SIZE;
    localparam int LAGS     = `ACF_LAGS;

    typedef enum logic [2:0] {
        PAT_CONST,
        PAT_ALT,
        PAT_RAMP,
        PAT_RANDOM,
        PAT_ZERO
    } pattern_e;

    // one table row per block where drop marks a block that ends while the previous is busy
    typedef struct packed {
        pattern_e    kind;
        logic [15:0] gap;
        logic        drop;
    } row_t;

    logic               iClock;
    logic               rst_n;
    logic               sample_valid;
    acf_pkg::sample_t   sample;
    logic               coef_valid;
    acf_pkg::acf_coef_t coef;
    logic               block_done;
    logic               overrun;

    row_t             rows [NUM_ROWS];
    acf_pkg::sample_t blk_samples [BLOCK];
    longint           exp_sum [NUM_ROWS][LAGS+1];
    logic [31:0]      exp_norm [NUM_ROWS][LAGS+1];
    int               cur_block      = 0;
    int               cur_lag        = 0;
    int               blocks_checked = 0;
    int               blocks_ended   = 0;
    int               last_ended     = 0;
    int               overrun_seen   = 0;
    int               drop_count     = 0;
    int               cycle_count    = 0;
    int               timeout_limit  = 0;

    autocorrelation_top dut0 (
        .iClock       (iClock),
        .rst_n        (rst_n),
        .sample_valid (sample_valid),
        .sample       (sample),
        .coef_valid   (coef_valid),
        .coef         (coef),
        .block_done   (block_done),
        .overrun      (overrun)
    );

    initial begin
        iClock = 1'b0;
        forever #50 iClock = ~iClock;
    end

    task automatic check_value(input longint actual, input longint expected, input string msg);
        if (actual !== expected) begin
            $display("ERROR at time %0t: %s (actual %0h, expected %0h)",
                     $time, msg, actual, expected);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    task automatic load_table();
        rows[0] = '{PAT_CONST,  16'd200, 1'b0};
        rows[1] = '{PAT_ALT,    16'd0,   1'b0};
        rows[2] = '{PAT_RAMP,   16'd250, 1'b1};
        rows[3] = '{PAT_RANDOM, 16'd200, 1'b0};
        rows[4] = '{PAT_ZERO,   16'd200, 1'b0};
        rows[5] = '{PAT_RANDOM, 16'd0,   1'b0};
        rows[6] = '{PAT_RAMP,   16'd200, 1'b1};
        rows[7] = '{PAT_ALT,    16'd200, 1'b0};
        // a random block can take up to twice its length with idle cycles
        timeout_limit = 100;
        for (int r = 0; r < NUM_ROWS; r++) begin
            timeout_limit += 2 * BLOCK + int'(rows[r].gap) + 200;
            drop_count    += int'(rows[r].drop);
        end
    endtask

    function automatic acf_pkg::sample_t pattern_value(input pattern_e kind, input int n);
        case (kind)
            PAT_CONST:  return acf_pkg::sample_t'(23456);
            PAT_ALT:    return (n % 2) ? acf_pkg::sample_t'(-32768) : acf_pkg::sample_t'(32767);
            PAT_RAMP:   return acf_pkg::sample_t'(n * 500 - 16000);
            PAT_RANDOM: return acf_pkg::sample_t'($urandom);
            default:    return '0;
        endcase
    endfunction

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------
    function automatic logic [31:0] float_from_sum(input longint v);
        longint      mag;
        int          pos;
        logic [63:0] frac;
        if (v == 0) begin
            return 32'd0;
        end
        mag = (v < 0) ? -v : v;
        pos = 0;
        while ((mag >> (pos + 1)) != 0) begin
            pos++;
        end
        // keep the 23 bits right below the leading one and cut off the rest
        if (pos >= 23) begin
            frac = mag >> (pos - 23);
        end else begin
            frac = mag << (23 - pos);
        end
        return {(v < 0), 8'(127 + pos), frac[22:0]};
    endfunction

    function automatic logic [31:0] divide_float(input logic [31:0] num, input logic [31:0] den);
        longint      sig_n;
        longint      sig_d;
        logic [63:0] q;
        int          e;
        if (num[30:23] == 0 || den[30:23] == 0) begin
            return 32'd0;
        end
        sig_n = 64'h80_0000 | num[22:0];
        sig_d = 64'h80_0000 | den[22:0];
        // 25 quotient bits of the significand ratio are kept by truncation
        q = (sig_n << 24) / sig_d;
        e = int'(num[30:23]) - int'(den[30:23]) + 127;
        if (q[24]) begin
            return {num[31] ^ den[31], 8'(e), q[23:1]};
        end else begin
            return {num[31] ^ den[31], 8'(e - 1), q[22:0]};
        end
    endfunction

    task automatic model_block(input int b);
        longint acc;
        for (int k = 0; k <= LAGS; k++) begin
            acc = 0;
            // products start at sample k so nothing reaches into the previous block
            for (int n = k; n < BLOCK; n++) begin
                acc += longint'(blk_samples[n]) * longint'(blk_samples[n-k]);
            end
            exp_sum[b][k] = acc;
        end
        for (int k = 0; k <= LAGS; k++) begin
            exp_norm[b][k] = divide_float(float_from_sum(exp_sum[b][k]),
                                          float_from_sum(exp_sum[b][0]));
        end
    endtask

    task automatic drive_sample(input acf_pkg::sample_t v);
        @(posedge iClock);
        #10;
        sample_valid = 1'b1;
        sample       = v;
    endtask

    task automatic drive_idle();
        @(posedge iClock);
        #10;
        sample_valid = 1'b0;
        sample       = acf_pkg::sample_t'($urandom);
    endtask

    // ------------------------------------------------------------
    // the monitor samples outputs on the falling edge
    // ------------------------------------------------------------
    always @(negedge iClock) begin
        if (overrun) begin
            check_value(blocks_ended > 0, 1, "overrun raised before any block was sent");
            check_value(rows[last_ended].drop, 1, "overrun raised for a block that should be kept");
            overrun_seen++;
        end
        if (coef_valid) begin
            if (cur_lag == 0) begin
                while (cur_block < NUM_ROWS && rows[cur_block].drop) begin
                    cur_block++;
                end
            end
            check_value(cur_block < blocks_ended, 1, "record for a block that was never sent");
            check_value(coef.lag, cur_lag, "lag index out of order");
            check_value(coef.raw_sum, exp_sum[cur_block][cur_lag], "raw lag sum");
            if (cur_lag == 0) begin
                // lag 0 over itself is exactly one and a silent block gives zero
                check_value(coef.norm, (exp_sum[cur_block][0] == 0) ? 0 : 32'h3F80_0000,
                            "lag 0 coefficient");
            end else begin
                check_value(coef.norm, exp_norm[cur_block][cur_lag], "normalized coefficient");
            end
            check_value(block_done, cur_lag == LAGS, "block_done not with the last lag");
            if (cur_lag == LAGS) begin
                cur_lag = 0;
                cur_block++;
                blocks_checked++;
            end else begin
                cur_lag++;
            end
        end else begin
            check_value(block_done, 0, "block_done without a record");
        end
    end

    always @(posedge iClock) begin
        cycle_count++;
        if (cycle_count > timeout_limit) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_limit);
            $display("TEST FAIL");
            $fatal(1);
        end
    end

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    initial begin
        int seed_init;
        rst_n        = 1'b0;
        sample_valid = 1'b0;
        sample       = '0;
        seed_init    = $urandom(51);
        load_table();
        repeat (8) @(posedge iClock);
        #10;
        rst_n = 1'b1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int n = 0; n < BLOCK; n++) begin
                blk_samples[n] = pattern_value(rows[r].kind, n);
            end
            model_block(r);
            for (int n = 0; n < BLOCK; n++) begin
                drive_sample(blk_samples[n]);
                // random blocks also get idle cycles between their samples
                if (rows[r].kind == PAT_RANDOM && $urandom_range(3) == 0) begin
                    drive_idle();
                end
            end
            last_ended   = r;
            blocks_ended = r + 1;
            repeat (rows[r].gap) drive_idle();
        end
        wait (blocks_checked == NUM_ROWS - drop_count);
        repeat (20) drive_idle();
        check_value(overrun_seen, drop_count, "overrun pulses do not match dropped blocks");
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+.
acf_pkg.sv
acf_accumulator.sv
int_to_float.sv
fp_divider.sv
acf_normalizer.sv
autocorrelation_top.sv
tb_autocorrelation.sv
